//--- logic/trapPkg.sv
package trapPkg;

    // Fixed data addresses
    localparam logic [31:0] HOST_ADDR          = 32'h0000_0100;
    localparam logic [31:0] MTIME_ADDR_LOW     = 32'h0200_BFF8;
    localparam logic [31:0] MTIMECMP_ADDR_LOW  = 32'h0200_C010;
    localparam logic [31:0] MTIMECMP_ADDR_HIGH = 32'h0200_C014;

    // Memory access kind, zero means no data access
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } memInstType_e;

    // Machine cause codes
    typedef enum logic [31:0] {
        M_INSTR_MISALIGN = 32'd0,
        M_INSTR_AFAULT   = 32'd1,
        M_ILL_INSTR      = 32'd2,
        M_BREAKPOINT     = 32'd3,
        M_LOAD_MISALIGN  = 32'd4,
        M_LOAD_AFAULT    = 32'd5,
        M_STORE_MISALIGN = 32'd6,
        M_STORE_AFAULT   = 32'd7,
        M_ECALL_M        = 32'd11,
        M_TIMER_INT      = 32'h8000_0007
    } excCause_e;

    // One instruction as seen by the trap logic
    typedef struct packed {
        logic         shouldJump;
        logic [31:0]  pcJumpDst;
        logic [31:0]  pc;
        logic [31:0]  dataAddress;
        memInstType_e memInstType;
        logic         instInvalid;
        logic         priv;
        excCause_e    privCause;
    } excReq_t;

    // Detector result
    typedef struct packed {
        logic        present;
        excCause_e   cause;
        logic [31:0] info;
    } trapRecord_t;

endpackage

//--- logic/excDetect.sv
`timescale 1ns/10ps

module excDetect #(
    parameter int unsigned RAM_WIDTH = 16,
    parameter logic [31:0] RAM_BASE  = 32'h8000_0000
) (
    input  trapPkg::excReq_t     req_i,
    input  logic                 timerExc_i,
    output trapPkg::trapRecord_t excRec_o
);

    logic jumpMisalign;
    logic pcInRam;
    logic dataInRam;
    logic dataInTimer;
    logic dataLegal;
    logic dataAccess;
    logic isStore;
    logic needHalf;
    logic needWord;
    logic misaligned;

    assign jumpMisalign = req_i.shouldJump && (req_i.pcJumpDst[1:0] != 2'b00);
    assign pcInRam      = req_i.pc[31:RAM_WIDTH] == RAM_BASE[31:RAM_WIDTH];
    assign dataInRam    = req_i.dataAddress[31:RAM_WIDTH] == RAM_BASE[31:RAM_WIDTH];

    // Whole timer block counts as legal
    assign dataInTimer = (req_i.dataAddress >= trapPkg::MTIME_ADDR_LOW)
                      && (req_i.dataAddress <= trapPkg::MTIMECMP_ADDR_HIGH);
    assign dataLegal   = (req_i.dataAddress == trapPkg::HOST_ADDR) || dataInRam || dataInTimer;
    assign dataAccess  = req_i.memInstType != trapPkg::MEM_NONE;

    // Access width and direction
    always_comb begin
        isStore  = 1'b0;
        needHalf = 1'b0;
        needWord = 1'b0;
        case (req_i.memInstType)
            trapPkg::MEM_LH, trapPkg::MEM_LHU: begin
                needHalf = 1'b1;
            end
            trapPkg::MEM_LW: begin
                needWord = 1'b1;
            end
            trapPkg::MEM_SB: begin
                isStore = 1'b1;
            end
            trapPkg::MEM_SH: begin
                isStore  = 1'b1;
                needHalf = 1'b1;
            end
            trapPkg::MEM_SW: begin
                isStore  = 1'b1;
                needWord = 1'b1;
            end
            default: begin
                isStore = 1'b0;
            end
        endcase
    end

    assign misaligned = (needHalf && req_i.dataAddress[0])
                     || (needWord && (req_i.dataAddress[1:0] != 2'b00));

    // Highest priority first
    always_comb begin
        excRec_o.present = 1'b1;
        excRec_o.cause   = trapPkg::M_INSTR_MISALIGN;
        excRec_o.info    = '0;
        if (jumpMisalign) begin
            excRec_o.info = req_i.pcJumpDst;
        end else if (!pcInRam) begin
            excRec_o.cause = trapPkg::M_INSTR_AFAULT;
            excRec_o.info  = req_i.pc;
        end else if (req_i.instInvalid) begin
            excRec_o.cause = trapPkg::M_ILL_INSTR;
            excRec_o.info  = req_i.pc;
        end else if (req_i.priv) begin
            excRec_o.cause = req_i.privCause;
            excRec_o.info  = req_i.pc;
        end else if (dataAccess && !dataLegal) begin
            excRec_o.info = req_i.dataAddress;
            if (isStore) begin
                excRec_o.cause = trapPkg::M_STORE_AFAULT;
            end else begin
                excRec_o.cause = trapPkg::M_LOAD_AFAULT;
            end
        end else if (dataAccess && misaligned) begin
            excRec_o.info = req_i.dataAddress;
            if (isStore) begin
                excRec_o.cause = trapPkg::M_STORE_MISALIGN;
            end else begin
                excRec_o.cause = trapPkg::M_LOAD_MISALIGN;
            end
        end else if (timerExc_i) begin
            excRec_o.cause = trapPkg::M_TIMER_INT;
        end else begin
            excRec_o.present = 1'b0;
        end
    end

endmodule

//--- logic/machineTimer.sv
`timescale 1ns/10ps

module machineTimer (
    input  logic                  clk_i,
    input  logic                  arstN_i,
    input  logic                  retire_i,
    input  logic [31:0]           dataAddress_i,
    input  trapPkg::memInstType_e memInstType_i,
    input  logic [31:0]           storeData_i,
    output logic                  timerPending_o
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        wordStore;
    logic        cmpLowWrite;
    logic        cmpHighWrite;

    // Only retired word stores reach mtimecmp
    assign wordStore    = retire_i && (memInstType_i == trapPkg::MEM_SW);
    assign cmpLowWrite  = wordStore && (dataAddress_i == trapPkg::MTIMECMP_ADDR_LOW);
    assign cmpHighWrite = wordStore && (dataAddress_i == trapPkg::MTIMECMP_ADDR_HIGH);

    // Free running counter
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            mtimecmp <= '1;
        end else begin
            if (cmpLowWrite) begin
                mtimecmp[31:0] <= storeData_i;
            end
            if (cmpHighWrite) begin
                mtimecmp[63:32] <= storeData_i;
            end
        end
    end

    // Pending level lags the counter by one cycle
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            timerPending_o <= 1'b0;
        end else begin
            timerPending_o <= mtime >= mtimecmp;
        end
    end

endmodule

//--- logic/trapCsrFile.sv
`timescale 1ns/10ps

module trapCsrFile #(
    parameter logic [31:0] TRAP_VECTOR = 32'h8000_0100
) (
    input  logic                 clk_i,
    input  logic                 arstN_i,
    input  logic                 instValid_i,
    input  logic                 mret_i,
    input  trapPkg::trapRecord_t excRec_i,
    input  logic [31:0]          pc_i,
    input  logic                 timerPending_i,
    output logic                 timerExc_o,
    output logic                 retire_o,
    output logic                 trapTaken_o,
    output logic [31:0]          trapPc_o,
    output logic [31:0]          mcause_o,
    output logic [31:0]          mepc_o,
    output logic [31:0]          mtval_o
);

    logic        mie;
    logic [31:0] mcause;
    logic [31:0] mepc;
    logic [31:0] mtval;

    // Interrupt masked while a handler runs
    assign timerExc_o = timerPending_i && mie;

    assign trapTaken_o = instValid_i && excRec_i.present;
    assign retire_o    = instValid_i && !excRec_i.present;

    // mret and a trap never coincide
    assign trapPc_o = mret_i ? mepc : TRAP_VECTOR;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            mie <= 1'b1;
        end else if (trapTaken_o) begin
            mie <= 1'b0;
        end else if (mret_i) begin
            mie <= 1'b1;
        end
    end

    // Trap record
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            mcause <= '0;
            mepc   <= '0;
            mtval  <= '0;
        end else if (trapTaken_o) begin
            mcause <= excRec_i.cause;
            mepc   <= pc_i;
            mtval  <= excRec_i.info;
        end
    end

    assign mcause_o = mcause;
    assign mepc_o   = mepc;
    assign mtval_o  = mtval;

endmodule

//--- logic/trapUnit.sv
`timescale 1ns/10ps

module trapUnit #(
    parameter int unsigned RAM_WIDTH   = 16,
    parameter logic [31:0] RAM_BASE    = 32'h8000_0000,
    parameter logic [31:0] TRAP_VECTOR = 32'h8000_0100
) (
    input  logic             clk_i,
    input  logic             arstN_i,
    input  logic             instValid_i,
    input  logic             mret_i,
    input  trapPkg::excReq_t req_i,
    input  logic [31:0]      storeData_i,
    output logic             trapTaken_o,
    output logic [31:0]      trapPc_o,
    output logic [31:0]      mcause_o,
    output logic [31:0]      mepc_o,
    output logic [31:0]      mtval_o
);

    trapPkg::trapRecord_t excRec;
    logic                 timerPending;
    logic                 timerExc;
    logic                 retire;

    excDetect #(
        .RAM_WIDTH (RAM_WIDTH),
        .RAM_BASE  (RAM_BASE)
    ) i_excDetect (
        .req_i      (req_i),
        .timerExc_i (timerExc),
        .excRec_o   (excRec)
    );

    machineTimer i_machineTimer (
        .clk_i          (clk_i),
        .arstN_i        (arstN_i),
        .retire_i       (retire),
        .dataAddress_i  (req_i.dataAddress),
        .memInstType_i  (req_i.memInstType),
        .storeData_i    (storeData_i),
        .timerPending_o (timerPending)
    );

    trapCsrFile #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) i_trapCsrFile (
        .clk_i          (clk_i),
        .arstN_i        (arstN_i),
        .instValid_i    (instValid_i),
        .mret_i         (mret_i),
        .excRec_i       (excRec),
        .pc_i           (req_i.pc),
        .timerPending_i (timerPending),
        .timerExc_o     (timerExc),
        .retire_o       (retire),
        .trapTaken_o    (trapTaken_o),
        .trapPc_o       (trapPc_o),
        .mcause_o       (mcause_o),
        .mepc_o         (mepc_o),
        .mtval_o        (mtval_o)
    );

endmodule

//--- sim/trapUnit_assert.sv
`timescale 1ns/10ps

module trapUnitAssert #(
    parameter logic [31:0] TRAP_VECTOR = 32'h8000_0100
) (
    input logic        clk_i,
    input logic        arstN_i,
    input logic        instValid_i,
    input logic        mret_i,
    input logic        trapTaken_o,
    input logic [31:0] trapPc_o
);

    int assertFails = 0;

    trapNeedsValid: assert property (@(posedge clk_i) disable iff (!arstN_i)
        trapTaken_o |-> instValid_i)
    else begin
        assertFails++;
        $error("trapTaken_o high without instValid_i");
    end

    trapGoesToVector: assert property (@(posedge clk_i) disable iff (!arstN_i)
        trapTaken_o |-> (trapPc_o == TRAP_VECTOR))
    else begin
        assertFails++;
        $error("trapPc_o differs from the trap vector during a trap");
    end

    // mret only follows a handler, never a trapping instruction
    noMretWithTrap: assert property (@(posedge clk_i) disable iff (!arstN_i)
        !(mret_i && trapTaken_o))
    else begin
        assertFails++;
        $error("mret_i and trapTaken_o high together");
    end

endmodule

bind trapUnit trapUnitAssert #(.TRAP_VECTOR(TRAP_VECTOR)) i_trapUnitAssert (.*);

//--- sim/trapUnitTb.sv
`timescale 1ns/10ps

module trapUnitTb;

    localparam int unsigned RAM_WIDTH   = 16;
    localparam logic [31:0] RAM_BASE    = 32'h8000_0000;
    localparam logic [31:0] TRAP_VECTOR = 32'h8000_0100;
    localparam int RANDOM_COUNT = 300;
    localparam int TIMER_WAIT   = 64;
    // Reset, directed, random and timer phases, doubled
    localparam int TIMEOUT_LIMIT = 2 * (16 + 20 + RANDOM_COUNT + TIMER_WAIT + 20);

    logic             clk;
    logic             arstN;
    logic             instValid;
    logic             mret;
    trapPkg::excReq_t req;
    logic [31:0]      storeData;
    logic             trapTaken;
    logic [31:0]      trapPc;
    logic [31:0]      mcause;
    logic [31:0]      mepc;
    logic [31:0]      mtval;

    integer      seed;
    int          checkCount = 0;
    int          errorCount = 0;
    int          timerTraps = 0;
    int          cycleCounter = 0;
    logic        lastTrap;
    logic        modelMie;
    logic        modelPending;
    logic [63:0] modelMtime;
    logic [63:0] modelCmp;
    logic [31:0] expMcause;
    logic [31:0] expMepc;
    logic [31:0] expMtval;

    trapUnit #(
        .RAM_WIDTH   (RAM_WIDTH),
        .RAM_BASE    (RAM_BASE),
        .TRAP_VECTOR (TRAP_VECTOR)
    ) i_dut (
        .clk_i       (clk),
        .arstN_i     (arstN),
        .instValid_i (instValid),
        .mret_i      (mret),
        .req_i       (req),
        .storeData_i (storeData),
        .trapTaken_o (trapTaken),
        .trapPc_o    (trapPc),
        .mcause_o    (mcause),
        .mepc_o      (mepc),
        .mtval_o     (mtval)
    );

    always #50 clk = ~clk;

    function automatic logic inRam(input logic [31:0] addr);
        return (addr >> RAM_WIDTH) == (RAM_BASE >> RAM_WIDTH);
    endfunction

    function automatic trapPkg::excReq_t nopReq(input logic [31:0] pc);
        trapPkg::excReq_t r;
        r = '0;
        r.pc          = pc;
        r.memInstType = trapPkg::MEM_NONE;
        r.privCause   = trapPkg::M_ECALL_M;
        return r;
    endfunction

    function automatic trapPkg::trapRecord_t expectTrap(input trapPkg::excReq_t r,
                                                        input logic timerInt);
        trapPkg::trapRecord_t rec;
        int unsigned bytes;
        logic        store;
        logic        legal;
        logic        access;
        store = 1'b0;
        bytes = 1;
        case (r.memInstType)
            trapPkg::MEM_LH, trapPkg::MEM_LHU: bytes = 2;
            trapPkg::MEM_LW: bytes = 4;
            trapPkg::MEM_SB: store = 1'b1;
            trapPkg::MEM_SH: begin
                store = 1'b1;
                bytes = 2;
            end
            trapPkg::MEM_SW: begin
                store = 1'b1;
                bytes = 4;
            end
            default: bytes = 1;
        endcase
        access = r.memInstType != trapPkg::MEM_NONE;
        legal  = (r.dataAddress == trapPkg::HOST_ADDR) || inRam(r.dataAddress)
              || (r.dataAddress >= trapPkg::MTIME_ADDR_LOW
                  && r.dataAddress <= trapPkg::MTIMECMP_ADDR_HIGH);
        rec.present = 1'b1;
        rec.cause   = trapPkg::M_INSTR_MISALIGN;
        rec.info    = 32'd0;
        if (r.shouldJump && (r.pcJumpDst % 4 != 0)) begin
            rec.info = r.pcJumpDst;
        end else if (!inRam(r.pc)) begin
            rec.cause = trapPkg::M_INSTR_AFAULT;
            rec.info  = r.pc;
        end else if (r.instInvalid) begin
            rec.cause = trapPkg::M_ILL_INSTR;
            rec.info  = r.pc;
        end else if (r.priv) begin
            rec.cause = r.privCause;
            rec.info  = r.pc;
        end else if (access && !legal) begin
            rec.cause = store ? trapPkg::M_STORE_AFAULT : trapPkg::M_LOAD_AFAULT;
            rec.info  = r.dataAddress;
        end else if (access && (r.dataAddress % bytes != 0)) begin
            rec.cause = store ? trapPkg::M_STORE_MISALIGN : trapPkg::M_LOAD_MISALIGN;
            rec.info  = r.dataAddress;
        end else if (timerInt) begin
            rec.cause = trapPkg::M_TIMER_INT;
        end else begin
            rec.present = 1'b0;
        end
        return rec;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic driveInst(input trapPkg::excReq_t r, input logic [31:0] data);
        @(negedge clk);
        req       = r;
        storeData = data;
        instValid = 1'b1;
        mret      = 1'b0;
    endtask

    task automatic driveNoInst(input logic doMret);
        @(negedge clk);
        req       = nopReq(RAM_BASE);
        instValid = 1'b0;
        mret      = doMret;
    endtask

    // Model of the timer, MIE and trap record, checked every edge
    always @(posedge clk) begin
        trapPkg::trapRecord_t expRec;
        logic nextPending;
        if (!arstN) begin
            modelMie     = 1'b1;
            modelPending = 1'b0;
            modelMtime   = '0;
            modelCmp     = '1;
            expMcause    = '0;
            expMepc      = '0;
            expMtval     = '0;
            lastTrap     = 1'b0;
        end else begin
            checkValue("mcause_o", mcause, expMcause);
            checkValue("mepc_o", mepc, expMepc);
            checkValue("mtval_o", mtval, expMtval);
            if (lastTrap && mcause == trapPkg::M_TIMER_INT && mtval == 32'd0) begin
                timerTraps++;
            end
            lastTrap = instValid && trapTaken;
            expRec   = expectTrap(req, modelPending && modelMie);
            if (instValid) begin
                checkValue("trapTaken_o", trapTaken, expRec.present);
                if (expRec.present) begin
                    checkValue("trapPc_o", trapPc, TRAP_VECTOR);
                end
            end
            if (mret) begin
                checkValue("trapPc_o", trapPc, expMepc);
            end
            nextPending = modelMtime >= modelCmp;
            modelMtime  = modelMtime + 64'd1;
            if (instValid && expRec.present) begin
                expMcause = expRec.cause;
                expMepc   = req.pc;
                expMtval  = expRec.info;
                modelMie  = 1'b0;
            end else if (mret) begin
                modelMie = 1'b1;
            end
            if (instValid && !expRec.present && req.memInstType == trapPkg::MEM_SW) begin
                if (req.dataAddress == trapPkg::MTIMECMP_ADDR_LOW) begin
                    modelCmp[31:0] = storeData;
                end
                if (req.dataAddress == trapPkg::MTIMECMP_ADDR_HIGH) begin
                    modelCmp[63:32] = storeData;
                end
            end
            modelPending = nextPending;
        end
    end

    always @(posedge clk) begin
        cycleCounter++;
        if (cycleCounter >= TIMEOUT_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        trapPkg::excReq_t r;
        logic [31:0]      rnd;
        int               kind;
        int               waited;
        int               assertFails;
        seed      = 32'hc8dec176;
        clk       = 1'b0;
        arstN     = 1'b0;
        instValid = 1'b0;
        mret      = 1'b0;
        req       = nopReq(RAM_BASE);
        storeData = '0;
        repeat (16) @(negedge clk);
        arstN = 1'b1;

        // Jump misalign beats a pc outside RAM
        r = nopReq(32'h1000_0000);
        r.shouldJump = 1'b1;
        r.pcJumpDst  = RAM_BASE + 32'h203;
        driveInst(r, 32'd0);
        driveInst(nopReq(32'h1000_0000), 32'd0);
        r = nopReq(RAM_BASE + 32'h4);
        r.instInvalid = 1'b1;
        driveInst(r, 32'd0);
        r = nopReq(RAM_BASE + 32'h8);
        r.priv = 1'b1;
        driveInst(r, 32'd0);
        r.privCause = trapPkg::M_BREAKPOINT;
        driveInst(r, 32'd0);
        r.instInvalid = 1'b1;
        driveInst(r, 32'd0);
        r = nopReq(RAM_BASE + 32'hC);
        r.memInstType = trapPkg::MEM_LW;
        r.dataAddress = RAM_BASE + 32'h40;
        driveInst(r, 32'd0);
        driveInst(nopReq(RAM_BASE + 32'h10), 32'd0);

        // All ones store data keeps mtimecmp out of reach
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            rnd  = $random(seed);
            kind = $unsigned($random(seed)) % 4;
            r    = nopReq(RAM_BASE + i * 4);
            r.memInstType = trapPkg::memInstType_e'($unsigned($random(seed)) % 9);
            case (kind)
                0: r.dataAddress = RAM_BASE | (rnd & ((32'd1 << RAM_WIDTH) - 1));
                1: r.dataAddress = trapPkg::HOST_ADDR;
                2: r.dataAddress = trapPkg::MTIME_ADDR_LOW + (rnd % 32);
                default: r.dataAddress = {1'b0, rnd[30:0]};
            endcase
            driveInst(r, 32'hFFFF_FFFF);
        end

        // Leave the last handler so the timer interrupt is enabled again
        driveNoInst(1'b1);

        r = nopReq(RAM_BASE + 32'h800);
        r.memInstType = trapPkg::MEM_SW;
        r.dataAddress = trapPkg::MTIMECMP_ADDR_HIGH;
        driveInst(r, 32'd0);
        r.dataAddress = trapPkg::MTIMECMP_ADDR_LOW;
        driveInst(r, modelMtime[31:0] + 32'd16);
        waited = 0;
        while (timerTraps == 0 && waited < TIMER_WAIT) begin
            driveInst(nopReq(RAM_BASE + 32'h900), 32'd0);
            waited++;
        end
        if (timerTraps == 0) begin
            errorCount++;
            $display("Timer interrupt was not taken within %0d instructions", TIMER_WAIT);
        end
        // Handler runs with the interrupt masked
        repeat (8) driveInst(nopReq(RAM_BASE + 32'h904), 32'd0);
        if (timerTraps > 1) begin
            errorCount++;
            $display("A second timer interrupt was taken before mret");
        end
        driveNoInst(1'b1);
        driveNoInst(1'b0);
        driveNoInst(1'b0);
        @(negedge clk);

        assertFails = i_dut.i_trapUnitAssert.assertFails;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checkCount, errorCount, assertFails);
        if (errorCount + assertFails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- src.f
logic/trapPkg.sv
logic/excDetect.sv
logic/machineTimer.sv
logic/trapCsrFile.sv
logic/trapUnit.sv
sim/trapUnit_assert.sv
sim/trapUnitTb.sv
